// File: fifo_pkg.sv
package fifo_pkg;

    // write side word and read side lane
    localparam int WORD_WIDTH     = 32;
    localparam int LANE_WIDTH     = 8;
    localparam int LANES_PER_WORD = WORD_WIDTH / LANE_WIDTH;
    localparam int LANE_IDX_WIDTH = $clog2(LANES_PER_WORD);

    // storage depth in words
    localparam int WORD_DEPTH = 16;
    localparam int ADDR_WIDTH = $clog2(WORD_DEPTH);
    // one extra bit tells full from empty
    localparam int PTR_WIDTH  = ADDR_WIDTH + 1;

    // lane fill count has to reach WORD_DEPTH * LANES_PER_WORD
    localparam int LANE_COUNT_WIDTH = $clog2(WORD_DEPTH * LANES_PER_WORD) + 1;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [LANE_WIDTH-1:0] lane_t;
    typedef logic [ADDR_WIDTH-1:0] ram_addr_t;

    typedef struct packed {
        logic  en;
        word_t data;
    } wr_req_t;

    typedef struct packed {
        logic      en;
        ram_addr_t addr;
        word_t     data;
    } ram_wr_t;

    typedef struct packed {
        logic      en;
        ram_addr_t addr;
    } ram_rd_t;

    typedef struct packed {
        logic                        full;
        logic                        empty;
        logic [PTR_WIDTH-1:0]        wr_data_count;
        logic [LANE_COUNT_WIDTH-1:0] rd_data_count;
    } fifo_level_t;

    typedef enum logic [1:0] {
        READER_IDLE  = 2'd0,
        READER_FETCH = 2'd1,
        READER_HOLD  = 2'd2
    } reader_state_t;

endpackage

// File: word_ram.sv
module word_ram (
    input  logic              clock,
    input  fifo_pkg::ram_wr_t wr,
    input  fifo_pkg::ram_rd_t rd,
    output fifo_pkg::word_t   rd_data
);

    import fifo_pkg::*;

    // simple dual port array, maps onto block ram
    word_t mem [WORD_DEPTH];

    // write port
    always_ff @(posedge clock) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, one cycle latency
    // output keeps the last word while the port is idle
    always_ff @(posedge clock) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

// File: fifo_pointers.sv
module fifo_pointers (
    input  logic                                  clock,
    input  logic                                  sys_rst,
    input  fifo_pkg::wr_req_t                     wr_req,
    input  logic                                  fetch,
    input  logic                                  pop,
    output fifo_pkg::ram_wr_t                     ram_wr,
    output fifo_pkg::ram_addr_t                   fetch_addr,
    output logic                                  fetch_ready,
    output logic [fifo_pkg::LANE_IDX_WIDTH-1:0]   rd_lane,
    output logic                                  head_last,
    output fifo_pkg::fifo_level_t                 level
);

    import fifo_pkg::*;

    // word pointers, msb is the wrap bit
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] fetch_ptr;
    logic [PTR_WIDTH-1:0] rel_ptr;

    // lane of the head word that is on the output
    logic [LANE_IDX_WIDTH-1:0] lane_idx;

    logic                        full;
    logic                        wr_accept;
    logic                        release_word;
    logic [PTR_WIDTH-1:0]        word_count;
    logic [LANE_COUNT_WIDTH-1:0] lane_count;

    // same slot, opposite lap
    assign full = (wr_ptr[PTR_WIDTH-1] != rel_ptr[PTR_WIDTH-1]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rel_ptr[ADDR_WIDTH-1:0]);

    assign wr_accept = wr_req.en && !full;

    assign head_last    = (lane_idx == LANE_IDX_WIDTH'(LANES_PER_WORD - 1));
    assign release_word = pop && head_last;

    // write pointer
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // next word to prefetch into the reader
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            fetch_ptr <= '0;
        end else if (fetch) begin
            fetch_ptr <= fetch_ptr + 1'b1;
        end
    end

    // head word stays occupied until its last lane leaves
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            rel_ptr <= '0;
        end else if (release_word) begin
            rel_ptr <= rel_ptr + 1'b1;
        end
    end

    // lane index wraps back to 0 after the last lane
    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            lane_idx <= '0;
        end else if (pop) begin
            lane_idx <= lane_idx + 1'b1;
        end
    end

    // memory write port
    always_comb begin
        ram_wr.en   = wr_accept;
        ram_wr.addr = wr_ptr[ADDR_WIDTH-1:0];
        ram_wr.data = wr_req.data;
    end

    // words written but not yet handed to the reader
    assign fetch_ready = (fetch_ptr != wr_ptr);
    assign fetch_addr  = fetch_ptr[ADDR_WIDTH-1:0];
    assign rd_lane     = lane_idx;

    // occupancy
    assign word_count = wr_ptr - rel_ptr;
    // lanes already popped from the head word are gone
    assign lane_count = LANE_COUNT_WIDTH'(word_count) * LANE_COUNT_WIDTH'(LANES_PER_WORD)
                      - LANE_COUNT_WIDTH'(lane_idx);

    always_comb begin
        level.full          = full;
        level.empty         = (lane_count == '0);
        level.wr_data_count = word_count;
        level.rd_data_count = lane_count;
    end

endmodule

// File: fwft_lane_reader.sv
module fwft_lane_reader (
    input  logic                                clock,
    input  logic                                sys_rst,
    input  logic                                rd_en,
    input  logic                                fetch_ready,
    input  fifo_pkg::ram_addr_t                 fetch_addr,
    input  logic [fifo_pkg::LANE_IDX_WIDTH-1:0] rd_lane,
    input  logic                                head_last,
    input  fifo_pkg::word_t                     ram_data,
    output fifo_pkg::ram_rd_t                   ram_rd,
    output logic                                fetch,
    output logic                                pop,
    output logic                                valid,
    output fifo_pkg::lane_t                     dout
);

    import fifo_pkg::*;

    reader_state_t state;
    reader_state_t state_next;

    // word currently being split into lanes
    word_t head_word;

    logic [LANE_IDX_WIDTH-1:0] lane_sel;

    // a head word is present only in hold
    assign valid = (state == READER_HOLD);
    assign pop   = rd_en && valid;

    always_comb begin
        state_next = state;
        fetch      = 1'b0;
        case (state)
            READER_IDLE: begin
                if (fetch_ready) begin
                    fetch      = 1'b1;
                    state_next = READER_FETCH;
                end
            end
            // ram output is valid in this cycle
            READER_FETCH: begin
                state_next = READER_HOLD;
            end
            READER_HOLD: begin
                if (pop && head_last) begin
                    // chain the next fetch so only one cycle is lost
                    if (fetch_ready) begin
                        fetch      = 1'b1;
                        state_next = READER_FETCH;
                    end else begin
                        state_next = READER_IDLE;
                    end
                end
            end
            default: begin
                state_next = READER_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge sys_rst) begin
        if (!sys_rst) begin
            state <= READER_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        ram_rd.en   = fetch;
        ram_rd.addr = fetch_addr;
    end

    // capture the prefetched word
    always_ff @(posedge clock) begin
        if (state == READER_FETCH) begin
            head_word <= ram_data;
        end
    end

    // lane 0 is the most significant byte
    assign lane_sel = LANE_IDX_WIDTH'(LANES_PER_WORD - 1) - rd_lane;
    assign dout     = head_word[lane_sel * LANE_WIDTH +: LANE_WIDTH];

endmodule

// File: width_fifo.sv
module width_fifo (
    input  logic                  clock,
    input  logic                  sys_rst,
    input  fifo_pkg::wr_req_t     wr_req,
    output logic                  wr_ready,
    input  logic                  rd_en,
    output logic                  valid,
    output fifo_pkg::lane_t       dout,
    output fifo_pkg::fifo_level_t level
);

    import fifo_pkg::*;

    ram_wr_t                   ram_wr;
    ram_rd_t                   ram_rd;
    word_t                     ram_data;
    ram_addr_t                 fetch_addr;
    logic                      fetch_ready;
    logic                      fetch;
    logic                      pop;
    logic [LANE_IDX_WIDTH-1:0] rd_lane;
    logic                      head_last;

    assign wr_ready = ~level.full;

    fifo_pointers u_pointers (
        .clock       (clock),
        .sys_rst     (sys_rst),
        .wr_req      (wr_req),
        .fetch       (fetch),
        .pop         (pop),
        .ram_wr      (ram_wr),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .rd_lane     (rd_lane),
        .head_last   (head_last),
        .level       (level)
    );

    word_ram u_ram (
        .clock   (clock),
        .wr      (ram_wr),
        .rd      (ram_rd),
        .rd_data (ram_data)
    );

    fwft_lane_reader u_reader (
        .clock       (clock),
        .sys_rst     (sys_rst),
        .rd_en       (rd_en),
        .fetch_ready (fetch_ready),
        .fetch_addr  (fetch_addr),
        .rd_lane     (rd_lane),
        .head_last   (head_last),
        .ram_data    (ram_data),
        .ram_rd      (ram_rd),
        .fetch       (fetch),
        .pop         (pop),
        .valid       (valid),
        .dout        (dout)
    );

endmodule

// File: tb_width_fifo.sv
module tb_width_fifo;

    import fifo_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 64;
    localparam int RAND_CYCLES     = 600;
    // room for three drains of up to 64 lanes plus bubbles
    localparam int DRAIN_CYCLES    = 3 * 100;
    localparam int TEST_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + DRAIN_CYCLES;
    localparam int WATCHDOG_MARGIN = 50 * CLK_PERIOD;

    logic        clock;
    logic        sys_rst;
    wr_req_t     wr_req;
    logic        wr_ready;
    logic        rd_en;
    logic        valid;
    lane_t       dout;
    fifo_level_t level;

    // reference model holds one entry per lane
    lane_t       lane_q[$];
    int          model_size = 0;
    int          model_words = 0;
    lane_t       model_front = '0;
    logic [31:0] rand_state;

    width_fifo UUT (
        .clock    (clock),
        .sys_rst  (sys_rst),
        .wr_req   (wr_req),
        .wr_ready (wr_ready),
        .rd_en    (rd_en),
        .valid    (valid),
        .dout     (dout),
        .level    (level)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // msb lane goes in first
    function automatic void push_lanes(input word_t w);
        for (int i = LANES_PER_WORD - 1; i >= 0; i--) begin
            lane_q.push_back(w[i * LANE_WIDTH +: LANE_WIDTH]);
        end
    endfunction

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("Error at time %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
        stop_on_failure();
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // model accepts a word only below its own word limit
    always @(posedge clock) begin
        if (!sys_rst) begin
            lane_q.delete();
        end else begin
            if (rd_en && valid && lane_q.size() > 0) begin
                void'(lane_q.pop_front());
            end
            if (wr_req.en && model_words < WORD_DEPTH) begin
                push_lanes(wr_req.data);
            end
        end
        model_size  = lane_q.size();
        model_words = (model_size + LANES_PER_WORD - 1) / LANES_PER_WORD;
        model_front = (model_size > 0) ? lane_q[0] : '0;
    end

    count_check: assert property (@(posedge clock) level.rd_data_count == model_size)
        else value_error("level.rd_data_count", $sampled(model_size),
                         $sampled(level.rd_data_count));

    words_check: assert property (@(posedge clock) level.wr_data_count == model_words)
        else value_error("level.wr_data_count", $sampled(model_words),
                         $sampled(level.wr_data_count));

    empty_check: assert property (@(posedge clock) level.empty == (model_size == 0))
        else value_error("level.empty", $sampled(model_size == 0), $sampled(level.empty));

    full_check: assert property (@(posedge clock) level.full == (model_words == WORD_DEPTH))
        else value_error("level.full", $sampled(model_words == WORD_DEPTH), $sampled(level.full));

    ready_check: assert property (@(posedge clock) wr_ready == (model_words != WORD_DEPTH))
        else value_error("wr_ready", $sampled(model_words != WORD_DEPTH), $sampled(wr_ready));

    valid_check: assert property (@(posedge clock) valid |-> model_size != 0)
        else begin
            $display("valid was high at time %0t while no lane was stored", $time);
            stop_on_failure();
        end

    data_check: assert property (@(posedge clock) disable iff (!sys_rst)
                                 (rd_en && valid) |-> dout == model_front)
        else value_error("dout", $sampled(model_front), $sampled(dout));

    // head lane must not move while the reader holds back
    hold_stable_check: assert property (@(posedge clock) disable iff (!sys_rst)
                                        (valid && !rd_en) |-> dout == model_front)
        else value_error("dout (held)", $sampled(model_front), $sampled(dout));

    task automatic write_burst(input int count, input word_t base);
        for (int i = 0; i < count; i++) begin
            wr_req.en   = 1'b1;
            wr_req.data = base + word_t'(i) * 32'h0404_0407;
            next_cycle();
        end
        wr_req.en = 1'b0;
    endtask

    task automatic drain();
        wr_req.en = 1'b0;
        rd_en     = 1'b1;
        next_cycle();
        while (model_size != 0) begin
            next_cycle();
        end
        rd_en = 1'b0;
        repeat (3) next_cycle();
    endtask

    task automatic random_mix();
        logic wr_pick;
        logic rd_pick;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            rand_state = lcg_next(rand_state);
            // the first half fills toward full and the second half mostly reads
            if (n < RAND_CYCLES / 2) begin
                wr_pick = (rand_state[31:30] == 2'd0);
                rd_pick = rand_state[28];
            end else begin
                wr_pick = (rand_state[31:29] == 3'd0);
                rd_pick = (rand_state[27:25] != 3'd0);
            end
            rd_en      = rd_pick;
            wr_req.en  = wr_pick;
            rand_state = lcg_next(rand_state);
            wr_req.data = rand_state;
            next_cycle();
        end
        wr_req.en = 1'b0;
    endtask

    initial begin
        sys_rst    = 1'b0;
        wr_req     = '0;
        rd_en      = 1'b0;
        rand_state = 32'ha341_d40e;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        sys_rst = 1'b1;
        // rd_en on an empty FIFO
        rd_en = 1'b1;
        repeat (4) next_cycle();
        rd_en = 1'b0;
        write_burst(4, 32'h1020_3040);
        drain();
        // one write more than fits and then a held head lane
        write_burst(WORD_DEPTH + 1, 32'h8001_c203);
        repeat (8) next_cycle();
        drain();
        random_mix();
        drain();
        if (model_size == 0 && level.empty && !valid) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("FIFO still holds data after the final drain");
            stop_on_failure();
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + WATCHDOG_MARGIN);
        $display("Timeout: the run did not finish within %0d clock cycles", TEST_CYCLES);
        stop_on_failure();
    end

endmodule

// File: project.f
fifo_pkg.sv
word_ram.sv
fifo_pointers.sv
fwft_lane_reader.sv
width_fifo.sv
tb_width_fifo.sv
